//--- verification/apu_testdata.txt
# write addr data | read addr expected | wait n | stall n  (addr and bytes hex, counts decimal)
# sink count zero | sink count any|all l0 l1 l2 l3 r0 r1  (allowed sample values, decimal)
# register readback with unused bits as one
write ff11 80
read ff11 bf
write ff12 a0
read ff12 a0
write ff13 d8
read ff13 ff
write ff14 47
read ff14 ff
write ff14 07
read ff14 bf
write ff16 7f
read ff16 7f
write ff17 52
read ff17 52
write ff24 73
read ff24 fb
write ff25 5a
read ff25 5a
read ff26 ff
read ff10 ff
# silence, nothing triggered
sink 8 zero
# channel 1, duty 2, volume 10, left only, volume_l 3
write ff24 31
read ff24 b9
write ff25 10
write ff12 a0
write ff14 87
wait 64
sink 16 all 0 40 40 40 0 0
# channel 2, volume 5, both sides
write ff25 32
write ff16 40
write ff17 50
write ff18 e8
write ff19 87
sink 24 any 0 20 40 60 0 10
# back-pressure
stall 1000
sink 12 any 0 20 40 60 0 10
# length counter stops channel 1
write ff25 10
write ff11 bf
write ff14 c7
wait 8192
sink 8 zero
# envelope fades channel 2 to zero
write ff25 22
write ff17 21
write ff19 87
wait 49152
sink 8 zero

//--- sources.f
hdl/apu_pkg.sv
hdl/apu_regs.sv
hdl/frame_sequencer.sv
hdl/square_channel.sv
hdl/sample_mixer.sv
hdl/sample_fifo.sv
hdl/apu_top.sv
verification/apu_tb.sv

//--- verification/apu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module apu_tb import apu_pkg::*; ();

  localparam int LINE_BITS         = 8 * 120;
  localparam int CYCLES_PER_SAMPLE = 64;
  localparam int MARGIN_CYCLES     = 2000;

  logic           clock;
  logic           tick_reset;
  reg_addr_t      tick_addr;
  reg_data_t      tick_data_in;
  logic           tick_write;
  logic           tick_read;
  reg_data_t      data_out;
  stereo_sample_t sample_out;
  logic           sample_valid;
  logic           sample_ready;

  // whole lines of the command file
  logic [LINE_BITS-1:0] lines [$];

  int             error_count;
  int             check_count;
  int             cycle_count;
  int             cycle_limit;

  // sink state, set on rising edges, used on falling edges
  logic           sink_active;
  logic           sink_zero;
  int             sink_left;
  int             left_set [4];
  int             right_set [2];
  logic [3:0]     left_seen;
  logic           stall_on;

  logic [31:0]    lcg_state;
  // head sample that was refused at the last falling edge
  logic           prev_waiting;
  stereo_sample_t prev_sample;

  apu_top i_apu_top (
    .clock        (clock),
    .tick_reset   (tick_reset),
    .tick_addr    (tick_addr),
    .tick_data_in (tick_data_in),
    .tick_write   (tick_write),
    .tick_read    (tick_read),
    .data_out     (data_out),
    .sample_out   (sample_out),
    .sample_valid (sample_valid),
    .sample_ready (sample_ready)
  );

  always #5 clock = ~clock;

  // --------------------
  // helpers
  // --------------------
  function automatic logic [31:0] next_random(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic check_value(input string name, input int expected, input int got);
    check_count++;
    if (expected != got) begin
      error_count++;
      $display("Fail %0t %s expected %0d got %0d", $time, name, expected, got);
    end
  endtask

  task automatic report_error(input string what);
    error_count++;
    $display("error at %0t: %s", $time, what);
  endtask

  // cycles a command may take, for the run limit
  function automatic int command_cycles(input logic [LINE_BITS-1:0] line);
    logic [63:0] cmd;
    int          n;
    int          fields;
    cmd    = '0;
    n      = 0;
    fields = $sscanf(line, "%s %d", cmd, n);
    if (fields < 2) return 0;
    if (cmd == "wait" || cmd == "stall") return n;
    if (cmd == "sink") return n * CYCLES_PER_SAMPLE;
    return 0;
  endfunction

  // --------------------
  // bus side
  // --------------------
  task automatic bus_write(input reg_addr_t addr, input reg_data_t data);
    @(negedge clock);
    tick_addr    = addr;
    tick_data_in = data;
    tick_write   = 1'b1;
    @(negedge clock);
    tick_write = 1'b0;
  endtask

  // data_out is valid one cycle after the read strobe
  task automatic bus_read(input reg_addr_t addr, input reg_data_t expected);
    @(negedge clock);
    tick_addr = addr;
    tick_read = 1'b1;
    @(negedge clock);
    tick_read = 1'b0;
    check_value($sformatf("data_out@%h", addr), expected, data_out);
  endtask

  task automatic hold_stall(input int n);
    @(posedge clock);
    stall_on = 1'b1;
    repeat (n) @(posedge clock);
    stall_on = 1'b0;
  endtask

  task automatic collect_samples(input int n, input logic zero_only, input logic need_all);
    @(posedge clock);
    sink_zero   = zero_only;
    left_seen   = '0;
    sink_left   = n;
    sink_active = 1'b1;
    while (sink_left > 0) @(posedge clock);
    sink_active = 1'b0;
    if (need_all) begin
      for (int i = 0; i < 4; i++) begin
        if (!left_seen[i]) begin
          report_error($sformatf("left value %0d never appeared", left_set[i]));
        end
      end
    end
  endtask

  // membership in the allowed sets, or zero on both sides
  task automatic check_sample(input stereo_sample_t s);
    logic left_ok;
    logic right_ok;
    left_ok  = 1'b0;
    right_ok = 1'b0;
    if (sink_zero) begin
      check_value("sample_out.left", 0, s.left);
      check_value("sample_out.right", 0, s.right);
    end else begin
      check_count++;
      for (int i = 0; i < 4; i++) begin
        if (s.left == left_set[i]) begin
          left_ok      = 1'b1;
          left_seen[i] = 1'b1;
        end
      end
      for (int i = 0; i < 2; i++) begin
        if (s.right == right_set[i]) right_ok = 1'b1;
      end
      if (!left_ok) report_error($sformatf("left sample %0d is not an allowed value", s.left));
      if (!right_ok) report_error($sformatf("right sample %0d is not an allowed value", s.right));
    end
  endtask

  // --------------------
  // sample sink
  // --------------------
  // outputs are stable here, a transfer happens at the next rising edge
  always @(negedge clock) begin
    if (prev_waiting) begin
      if (!sample_valid) begin
        report_error("sample_valid dropped before the sink took the sample");
      end else begin
        check_value("sample_out.left", prev_sample.left, sample_out.left);
        check_value("sample_out.right", prev_sample.right, sample_out.right);
      end
    end
    if (tick_reset || stall_on) begin
      sample_ready = 1'b0;
    end else begin
      // ready three times in four
      lcg_state    = next_random(lcg_state);
      sample_ready = (lcg_state[31:30] != 2'b00);
    end
    prev_waiting = sample_valid && !sample_ready;
    prev_sample  = sample_out;
    if (sample_valid && sample_ready && sink_active && (sink_left > 0)) begin
      check_sample(sample_out);
      sink_left--;
    end
  end

  // run limit
  always @(posedge clock) begin
    cycle_count++;
    if ((cycle_limit > 0) && (cycle_count >= cycle_limit)) begin
      $display("timeout: run still busy after %0d cycles", cycle_limit);
      $display("errors: %0d, checks: %0d", error_count, check_count);
      $display("Something failed");
      $finish;
    end
  end

  // --------------------
  // command decode
  // --------------------
  task automatic run_command(input logic [LINE_BITS-1:0] line);
    logic [63:0] cmd;
    logic [63:0] kind;
    int          fields;
    int          a;
    int          b;
    int          n;
    cmd    = '0;
    kind   = '0;
    fields = $sscanf(line, "%s", cmd);
    // blank lines and comments
    if (fields < 1 || cmd == "#") begin
    end else if (cmd == "write") begin
      fields = $sscanf(line, "%s %h %h", cmd, a, b);
      bus_write(a, b);
    end else if (cmd == "read") begin
      fields = $sscanf(line, "%s %h %h", cmd, a, b);
      bus_read(a, b);
    end else if (cmd == "wait") begin
      fields = $sscanf(line, "%s %d", cmd, n);
      repeat (n) @(posedge clock);
    end else if (cmd == "stall") begin
      fields = $sscanf(line, "%s %d", cmd, n);
      hold_stall(n);
    end else if (cmd == "sink") begin
      fields = $sscanf(line, "%s %d %s %d %d %d %d %d %d", cmd, n, kind,
                       left_set[0], left_set[1], left_set[2], left_set[3],
                       right_set[0], right_set[1]);
      if (kind == "zero") begin
        collect_samples(n, 1'b1, 1'b0);
      end else if (fields != 9) begin
        report_error("sink line does not have six allowed values");
      end else begin
        collect_samples(n, 1'b0, kind == "all");
      end
    end else begin
      report_error("unknown command in the testdata file");
    end
  endtask

  // --------------------
  // main sequence
  // --------------------
  initial begin : main
    int                   fd;
    int                   status;
    logic [LINE_BITS-1:0] line;
    clock        = 1'b0;
    tick_reset   = 1'b1;
    tick_addr    = '0;
    tick_data_in = '0;
    tick_write   = 1'b0;
    tick_read    = 1'b0;
    sample_ready = 1'b0;
    error_count  = 0;
    check_count  = 0;
    cycle_count  = 0;
    cycle_limit  = 0;
    sink_active  = 1'b0;
    sink_zero    = 1'b0;
    sink_left    = 0;
    left_seen    = '0;
    stall_on     = 1'b0;
    lcg_state    = 32'd67;
    prev_waiting = 1'b0;
    prev_sample  = '0;
    fd = $fopen("verification/apu_testdata.txt", "r");
    if (fd == 0) begin
      report_error("cannot open verification/apu_testdata.txt");
      $display("errors: %0d, checks: %0d", error_count, check_count);
      $display("Something failed");
      $finish;
    end else begin
      while (!$feof(fd)) begin
        line   = '0;
        status = $fgets(line, fd);
        if (status > 0) lines.push_back(line);
      end
      $fclose(fd);
      cycle_limit = MARGIN_CYCLES;
      foreach (lines[i]) cycle_limit += command_cycles(lines[i]);
      // reset for 4 cycles
      repeat (4) @(posedge clock);
      @(negedge clock);
      tick_reset = 1'b0;
      foreach (lines[i]) run_command(lines[i]);
      $display("errors: %0d, checks: %0d", error_count, check_count);
      if (error_count == 0) begin
        $display("Everything OK");
      end else begin
        $display("Something failed");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- hdl/apu_top.sv
`timescale 1ns/1ps
`default_nettype none

module apu_top import apu_pkg::*; (
  input  wire logic     clock,
  input  wire logic     tick_reset,
  input  reg_addr_t     tick_addr,
  input  reg_data_t     tick_data_in,
  input  wire logic     tick_write,
  input  wire logic     tick_read,
  output reg_data_t     data_out,
  output stereo_sample_t sample_out,
  output logic          sample_valid,
  input  wire logic     sample_ready
);

  square_cfg_t    ch1_cfg;
  square_cfg_t    ch2_cfg;
  logic           ch1_trigger;
  logic           ch2_trigger;
  mix_cfg_t       mix_cfg;
  logic           sample_tick;
  logic           length_tick;
  logic           env_tick;
  vol_t           ch1_level;
  vol_t           ch2_level;
  stereo_sample_t mix_sample;
  logic           mix_valid;
  logic           mix_ready;

  // --------------------
  // control
  // --------------------
  apu_regs i_apu_regs (
    .clock        (clock),
    .tick_reset   (tick_reset),
    .tick_addr    (tick_addr),
    .tick_data_in (tick_data_in),
    .tick_write   (tick_write),
    .tick_read    (tick_read),
    .data_out     (data_out),
    .ch1_cfg      (ch1_cfg),
    .ch2_cfg      (ch2_cfg),
    .ch1_trigger  (ch1_trigger),
    .ch2_trigger  (ch2_trigger),
    .mix_cfg      (mix_cfg)
  );

  frame_sequencer i_frame_sequencer (
    .clock       (clock),
    .tick_reset  (tick_reset),
    .sample_tick (sample_tick),
    .length_tick (length_tick),
    .env_tick    (env_tick)
  );

  // --------------------
  // channels
  // --------------------
  square_channel i_square_channel_1 (
    .clock       (clock),
    .tick_reset  (tick_reset),
    .cfg         (ch1_cfg),
    .trigger     (ch1_trigger),
    .length_tick (length_tick),
    .env_tick    (env_tick),
    .level       (ch1_level)
  );

  square_channel i_square_channel_2 (
    .clock       (clock),
    .tick_reset  (tick_reset),
    .cfg         (ch2_cfg),
    .trigger     (ch2_trigger),
    .length_tick (length_tick),
    .env_tick    (env_tick),
    .level       (ch2_level)
  );

  // --------------------
  // output path
  // --------------------
  sample_mixer i_sample_mixer (
    .clock       (clock),
    .tick_reset  (tick_reset),
    .sample_tick (sample_tick),
    .ch1_level   (ch1_level),
    .ch2_level   (ch2_level),
    .mix_cfg     (mix_cfg),
    .mix_sample  (mix_sample),
    .mix_valid   (mix_valid),
    .mix_ready   (mix_ready)
  );

  sample_fifo i_sample_fifo (
    .clock      (clock),
    .tick_reset (tick_reset),
    .in_sample  (mix_sample),
    .in_valid   (mix_valid),
    .in_ready   (mix_ready),
    .out_sample (sample_out),
    .out_valid  (sample_valid),
    .out_ready  (sample_ready)
  );

endmodule

`default_nettype wire

//--- hdl/sample_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sample_fifo import apu_pkg::*; (
  input  wire logic     clock,
  input  wire logic     tick_reset,
  input  stereo_sample_t in_sample,
  input  wire logic     in_valid,
  output logic          in_ready,
  output stereo_sample_t out_sample,
  output logic          out_valid,
  input  wire logic     out_ready
);

  stereo_sample_t                  mem [FIFO_DEPTH];
  // depth is a power of two, pointers wrap on their own
  logic [$clog2(FIFO_DEPTH)-1:0]   wr_ptr;
  logic [$clog2(FIFO_DEPTH)-1:0]   rd_ptr;
  logic [$clog2(FIFO_DEPTH):0]     count;
  logic                            push;
  logic                            pop;

  assign in_ready  = (count != FIFO_DEPTH);
  assign out_valid = (count != '0);
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;

  // head entry, stable until popped
  assign out_sample = mem[rd_ptr];

  always_ff @(posedge clock) begin
    if (push) begin
      mem[wr_ptr] <= in_sample;
    end
  end

  always_ff @(posedge clock) begin
    if (tick_reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      // simultaneous push and pop leaves count alone
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hdl/sample_mixer.sv
`timescale 1ns/1ps
`default_nettype none

module sample_mixer import apu_pkg::*; (
  input  wire logic     clock,
  input  wire logic     tick_reset,
  input  wire logic     sample_tick,
  input  vol_t          ch1_level,
  input  vol_t          ch2_level,
  input  mix_cfg_t      mix_cfg,
  output stereo_sample_t mix_sample,
  output logic          mix_valid,
  input  wire logic     mix_ready
);

  vol_t [NUM_CHANNELS-1:0] levels;
  stereo_sample_t          next_sample;
  logic                    can_load;

  assign levels = {ch2_level, ch1_level};

  // sum of panned levels, times code plus one
  function automatic sample_t mix_side(input vol_t [NUM_CHANNELS-1:0] lv,
                                       input logic [NUM_CHANNELS-1:0] pan,
                                       input master_vol_t vol);
    sample_t sum;
    sum = '0;
    for (int i = 0; i < NUM_CHANNELS; i++) begin
      if (pan[i]) sum = sum + sample_t'(lv[i]);
    end
    return sum * (sample_t'(vol) + sample_t'(1));
  endfunction

  assign next_sample.left  = mix_side(levels, mix_cfg.pan_l, mix_cfg.volume_l);
  assign next_sample.right = mix_side(levels, mix_cfg.pan_r, mix_cfg.volume_r);

  // slot free, or the pending one leaves this cycle
  assign can_load = !mix_valid || mix_ready;

  always_ff @(posedge clock) begin
    if (tick_reset) begin
      mix_valid <= 1'b0;
    end else if (sample_tick && can_load) begin
      mix_valid <= 1'b1;
    end else if (mix_ready) begin
      mix_valid <= 1'b0;
    end
  end

  // payload, tick skipped while a sample waits
  always_ff @(posedge clock) begin
    if (sample_tick && can_load) begin
      mix_sample <= next_sample;
    end
  end

endmodule

`default_nettype wire

//--- hdl/square_channel.sv
`timescale 1ns/1ps
`default_nettype none

module square_channel import apu_pkg::*; (
  input  wire logic  clock,
  input  wire logic  tick_reset,
  input  square_cfg_t cfg,
  input  wire logic  trigger,
  input  wire logic  length_tick,
  input  wire logic  env_tick,
  output vol_t       level
);

  logic        running;
  freq_t       freq_timer;
  phase_t      phase;
  len_t        len_count;
  env_period_t env_timer;
  vol_t        volume;
  logic        start;
  phase_t      duty_limit;
  logic        wave_high;

  // dac off when volume and direction are both zero
  assign start = trigger && ((cfg.env_vol_init != '0) || cfg.env_add);

  always_ff @(posedge clock) begin
    if (tick_reset) begin
      running    <= 1'b0;
      freq_timer <= '0;
      phase      <= '0;
      len_count  <= '0;
      env_timer  <= '0;
      volume     <= '0;
    end else begin
      // --------------------
      // frequency timer
      // --------------------
      if (freq_timer == '1) begin
        freq_timer <= cfg.freq_init;
        phase      <= phase + phase_t'(1);
      end else begin
        freq_timer <= freq_timer + freq_t'(1);
      end

      // --------------------
      // length counter
      // --------------------
      // counts up, stops at 63
      if (length_tick && running && cfg.len_en) begin
        if (len_count == '1) begin
          len_count <= '0;
          running   <= 1'b0;
        end else begin
          len_count <= len_count + len_t'(1);
        end
      end

      // --------------------
      // envelope
      // --------------------
      // period 0 freezes the volume
      if (env_tick && (cfg.env_period != '0)) begin
        if (env_timer <= env_period_t'(1)) begin
          // period expired, one step
          env_timer <= cfg.env_period;
          if (cfg.env_add) begin
            if (volume != 4'd15) volume <= volume + vol_t'(1);
          end else begin
            if (volume != 4'd0) volume <= volume - vol_t'(1);
          end
        end else begin
          env_timer <= env_timer - env_period_t'(1);
        end
      end

      // trigger overrides the updates above
      if (start) begin
        running    <= 1'b1;
        freq_timer <= cfg.freq_init;
        phase      <= '0;
        len_count  <= cfg.len_init;
        env_timer  <= cfg.env_period;
        volume     <= cfg.env_vol_init;
      end
    end
  end

  // --------------------
  // duty waveform
  // --------------------
  // high for 1, 2, 4 or 6 of 8 phases
  always_comb begin
    case (cfg.duty)
      2'd0:    duty_limit = 3'd1;
      2'd1:    duty_limit = 3'd2;
      2'd2:    duty_limit = 3'd4;
      default: duty_limit = 3'd6;
    endcase
  end

  assign wave_high = (phase < duty_limit);
  assign level     = (running && wave_high) ? volume : '0;

endmodule

`default_nettype wire

//--- hdl/frame_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module frame_sequencer import apu_pkg::*; (
  input  wire logic clock,
  input  wire logic tick_reset,
  output logic      sample_tick,
  output logic      length_tick,
  output logic      env_tick
);

  logic [15:0] div_count;
  logic [15:0] div_prev;
  // bits that went 0 -> 1 on the last increment
  logic [15:0] div_rise;

  always_ff @(posedge clock) begin
    if (tick_reset) begin
      div_count <= '0;
      div_prev  <= '0;
    end else begin
      div_count <= div_count + 16'd1;
      div_prev  <= div_count;
    end
  end

  assign div_rise = div_count & ~div_prev;

  // 64, 4096 and 16384 cycle periods
  assign sample_tick = div_rise[SAMPLE_TICK_BIT];
  assign length_tick = div_rise[LENGTH_TICK_BIT];
  assign env_tick    = div_rise[ENV_TICK_BIT];

endmodule

`default_nettype wire

//--- hdl/apu_regs.sv
`timescale 1ns/1ps
`default_nettype none

module apu_regs import apu_pkg::*; (
  input  wire logic  clock,
  input  wire logic  tick_reset,
  input  reg_addr_t  tick_addr,
  input  reg_data_t  tick_data_in,
  input  wire logic  tick_write,
  input  wire logic  tick_read,
  output reg_data_t  data_out,
  output square_cfg_t ch1_cfg,
  output square_cfg_t ch2_cfg,
  output logic       ch1_trigger,
  output logic       ch2_trigger,
  output mix_cfg_t   mix_cfg
);

  // offset of the bus address within each channel block
  reg_addr_t   ch1_offs;
  reg_addr_t   ch2_offs;
  master_vol_t vol_l;
  master_vol_t vol_r;
  // NR51 kept whole for readback
  reg_data_t   nr51;
  reg_data_t   rd_byte;

  assign ch1_offs = tick_addr - ADDR_NR11;
  assign ch2_offs = tick_addr - ADDR_NR21;

  // --------------------
  // per channel helpers
  // --------------------

  // sel 0..3 is NRx1..NRx4
  function automatic square_cfg_t square_write(input square_cfg_t cfg,
                                               input logic [1:0] sel,
                                               input reg_data_t data);
    square_cfg_t next;
    next = cfg;
    case (sel)
      2'd0: begin
        next.duty     = data[7:6];
        next.len_init = data[5:0];
      end
      2'd1: begin
        next.env_vol_init = data[7:4];
        next.env_add      = data[3];
        next.env_period   = data[2:0];
      end
      // low byte of the frequency
      2'd2: next.freq_init[7:0] = data;
      // high bits, trigger handled separately
      default: begin
        next.len_en          = data[6];
        next.freq_init[10:8] = data[2:0];
      end
    endcase
    return next;
  endfunction

  function automatic reg_data_t square_read(input square_cfg_t cfg, input logic [1:0] sel);
    case (sel)
      2'd0:    return {cfg.duty, READ_FILL[5:0]};
      2'd1:    return {cfg.env_vol_init, cfg.env_add, cfg.env_period};
      2'd2:    return READ_FILL;
      // trigger and frequency bits read as one
      default: return {1'b1, cfg.len_en, READ_FILL[5:0]};
    endcase
  endfunction

  // --------------------
  // writes
  // --------------------
  always_ff @(posedge clock) begin
    if (tick_reset) begin
      ch1_cfg     <= '0;
      ch2_cfg     <= '0;
      vol_l       <= '0;
      vol_r       <= '0;
      nr51        <= '0;
      ch1_trigger <= 1'b0;
      ch2_trigger <= 1'b0;
    end else begin
      // one cycle pulse, cfg already holds the new value then
      ch1_trigger <= tick_write && (tick_addr == ADDR_NR14) && tick_data_in[7];
      ch2_trigger <= tick_write && (tick_addr == ADDR_NR24) && tick_data_in[7];
      if (tick_write) begin
        case (tick_addr)
          ADDR_NR11, ADDR_NR12, ADDR_NR13, ADDR_NR14:
            ch1_cfg <= square_write(ch1_cfg, ch1_offs[1:0], tick_data_in);
          ADDR_NR21, ADDR_NR22, ADDR_NR23, ADDR_NR24:
            ch2_cfg <= square_write(ch2_cfg, ch2_offs[1:0], tick_data_in);
          ADDR_NR50: begin
            vol_l <= tick_data_in[6:4];
            vol_r <= tick_data_in[2:0];
          end
          ADDR_NR51: nr51 <= tick_data_in;
          // unmapped, ignored
          default: ;
        endcase
      end
    end
  end

  // --------------------
  // readback
  // --------------------
  always_comb begin
    rd_byte = READ_FILL;
    case (tick_addr)
      ADDR_NR11, ADDR_NR12, ADDR_NR13, ADDR_NR14:
        rd_byte = square_read(ch1_cfg, ch1_offs[1:0]);
      ADDR_NR21, ADDR_NR22, ADDR_NR23, ADDR_NR24:
        rd_byte = square_read(ch2_cfg, ch2_offs[1:0]);
      ADDR_NR50: rd_byte = {1'b1, vol_l, 1'b1, vol_r};
      ADDR_NR51: rd_byte = nr51;
      default: ;
    endcase
  end

  // holds until the next read
  always_ff @(posedge clock) begin
    if (tick_reset) begin
      data_out <= '0;
    end else if (tick_read) begin
      data_out <= rd_byte;
    end
  end

  // right pan in the low nibble, left in the high nibble
  assign mix_cfg = '{
    volume_l: vol_l,
    volume_r: vol_r,
    pan_l:    nr51[4 +: NUM_CHANNELS],
    pan_r:    nr51[0 +: NUM_CHANNELS]
  };

endmodule

`default_nettype wire

//--- hdl/apu_pkg.sv
`default_nettype none

package apu_pkg;

  // --------------------
  // bus and value types
  // --------------------
  typedef logic [15:0] reg_addr_t;
  typedef logic [7:0]  reg_data_t;

  typedef logic [10:0] freq_t;
  typedef logic [5:0]  len_t;
  typedef logic [3:0]  vol_t;
  typedef logic [2:0]  env_period_t;
  typedef logic [1:0]  duty_t;
  typedef logic [2:0]  phase_t;
  typedef logic [2:0]  master_vol_t;

  // one side of the output, max 30 * 8
  typedef logic [8:0]  sample_t;

  // --------------------
  // register map
  // --------------------
  localparam reg_addr_t ADDR_NR11 = 16'hFF11;
  localparam reg_addr_t ADDR_NR12 = 16'hFF12;
  localparam reg_addr_t ADDR_NR13 = 16'hFF13;
  localparam reg_addr_t ADDR_NR14 = 16'hFF14;
  localparam reg_addr_t ADDR_NR21 = 16'hFF16;
  localparam reg_addr_t ADDR_NR22 = 16'hFF17;
  localparam reg_addr_t ADDR_NR23 = 16'hFF18;
  localparam reg_addr_t ADDR_NR24 = 16'hFF19;
  localparam reg_addr_t ADDR_NR50 = 16'hFF24;
  localparam reg_addr_t ADDR_NR51 = 16'hFF25;

  // unused read bits
  localparam reg_data_t READ_FILL = 8'hFF;

  // divider bits, ticks on their rising edges
  localparam int LENGTH_TICK_BIT = 11;
  localparam int ENV_TICK_BIT    = 13;
  localparam int SAMPLE_TICK_BIT = 5;

  localparam int FIFO_DEPTH   = 8;
  localparam int NUM_CHANNELS = 2;

  // --------------------
  // structs
  // --------------------
  typedef struct packed {
    duty_t       duty;
    len_t        len_init;
    logic        len_en;
    env_period_t env_period;
    logic        env_add;
    vol_t        env_vol_init;
    freq_t       freq_init;
  } square_cfg_t;

  // pan bit i selects channel i+1
  typedef struct packed {
    master_vol_t             volume_l;
    master_vol_t             volume_r;
    logic [NUM_CHANNELS-1:0] pan_l;
    logic [NUM_CHANNELS-1:0] pan_r;
  } mix_cfg_t;

  typedef struct packed {
    sample_t left;
    sample_t right;
  } stereo_sample_t;

endpackage

`default_nettype wire
